// File: design/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// datapath and instruction width
`define MIPS_DATA_W         32

// register file
`define MIPS_NUM_REGS       32
`define MIPS_REG_AW         5

// memories, in words
`define MIPS_IMEM_DEPTH     128
`define MIPS_DMEM_DEPTH     128
`define MIPS_IMEM_AW        $clog2(`MIPS_IMEM_DEPTH)
`define MIPS_DMEM_AW        $clog2(`MIPS_DMEM_DEPTH)

// serial line
`define MIPS_CLKS_PER_BIT   16

`define MIPS_HALT_WORD      {`MIPS_DATA_W{1'b1}}

`endif

// File: design/mips_pkg.sv
`include "mips_cfg.svh"

package mips_pkg;

    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_addi  = 6'h08,
        op_ori   = 6'h0d,
        op_lw    = 6'h23,
        op_sw    = 6'h2b,
        op_halt  = 6'h3f
    } opcode_e;

    typedef enum logic [5:0] {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_e;

    // alu_add is zero so a cleared payload is harmless
    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_slt    = 3'd4,
        alu_pass_b = 3'd5
    } alu_op_e;

    typedef struct packed {
        logic [`MIPS_IMEM_AW-1:0] pc;
        logic [`MIPS_DATA_W-1:0]  instr;
    } if_id_t;

    typedef struct packed {
        logic [`MIPS_DATA_W-1:0] op_a;
        logic [`MIPS_DATA_W-1:0] op_b;
        logic [`MIPS_DATA_W-1:0] imm;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [`MIPS_REG_AW-1:0] rd;
        alu_op_e                 alu_op;
        logic                    use_imm;
        logic                    dest_is_rt;
        logic                    mem_read;
        logic                    mem_write;
        logic                    reg_write;
        logic                    halt;
    } id_ex_t;

    typedef struct packed {
        logic [`MIPS_DATA_W-1:0] alu_result;
        logic [`MIPS_DATA_W-1:0] store_data;
        logic [`MIPS_REG_AW-1:0] dest;
        logic                    mem_read;
        logic                    mem_write;
        logic                    reg_write;
        logic                    halt;
    } ex_mem_t;

    typedef struct packed {
        logic [`MIPS_DATA_W-1:0] alu_result;
        logic [`MIPS_DATA_W-1:0] mem_data;
        logic [`MIPS_REG_AW-1:0] dest;
        logic                    mem_to_reg;
        logic                    reg_write;
        logic                    halt;
    } mem_wb_t;

endpackage

// File: design/pipe_reg.sv
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clock_i,
    input  logic     rst_n_i,
    input  logic     en_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // zero is a bubble for every stage payload
    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            q_o <= '0;
        end else if (en_i) begin
            q_o <= d_i;
        end
    end

endmodule

// File: design/uart_rx.sv
`include "mips_cfg.svh"

module uart_rx (
    input  logic       clock_i,
    input  logic       rst_n_i,
    input  logic       rx_i,
    output logic [7:0] byte_o,
    output logic       byte_valid_o
);

    localparam int CNT_W = $clog2(`MIPS_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`MIPS_CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`MIPS_CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_e;

    state_e           state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [2:0]       bit_q;
    logic [1:0]       rx_sync_q;
    logic [7:0]       shift_q;
    logic             rx_s;
    logic             sample;

    assign rx_s   = rx_sync_q[1];
    assign sample = (cnt_q == '0);
    assign byte_o = shift_q;

    // two-flop sync, line idles high
    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            rx_sync_q <= 2'b11;
        end else begin
            rx_sync_q <= {rx_sync_q[0], rx_i};
        end
    end

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            state_q      <= st_idle;
            cnt_q        <= '0;
            bit_q        <= '0;
            byte_valid_o <= 1'b0;
        end else begin
            byte_valid_o <= 1'b0;
            cnt_q        <= sample ? FULL_BIT : cnt_q - 1'b1;
            case (state_q)
                st_idle: begin
                    cnt_q <= HALF_BIT;
                    if (!rx_s) state_q <= st_start; // falling edge of start bit
                end
                st_start: begin
                    bit_q <= '0;
                    if (sample) state_q <= rx_s ? st_idle : st_data; // glitch check
                end
                st_data: begin
                    if (sample) begin
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == 3'd7) state_q <= st_stop;
                    end
                end
                st_stop: begin
                    if (sample) begin
                        byte_valid_o <= rx_s; // bad stop bit drops the byte
                        state_q      <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clock_i) begin
        if (state_q == st_data && sample) shift_q <= {rx_s, shift_q[7:1]};
    end

endmodule

// File: design/program_loader.sv
`include "mips_cfg.svh"

module program_loader (
    input  logic                     clock_i,
    input  logic                     rst_n_i,
    input  logic [7:0]               byte_i,
    input  logic                     byte_valid_i,
    output logic                     imem_we_o,
    output logic [`MIPS_IMEM_AW-1:0] imem_addr_o,
    output logic [`MIPS_DATA_W-1:0]  imem_wdata_o,
    output logic                     run_en_o
);

    logic [1:0]              byte_cnt_q;
    logic [`MIPS_DATA_W-1:0] word_q;
    logic                    take;

    // once running, further bytes are ignored
    assign take         = byte_valid_i && !run_en_o;
    assign imem_wdata_o = word_q;

    // little-endian, first byte ends up in the low lane
    always_ff @(posedge clock_i) begin
        if (take) word_q <= {byte_i, word_q[`MIPS_DATA_W-1:8]};
    end

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            byte_cnt_q  <= '0;
            imem_we_o   <= 1'b0;
            imem_addr_o <= '0;
            run_en_o    <= 1'b0;
        end else begin
            imem_we_o <= take && (byte_cnt_q == 2'd3);
            if (take) byte_cnt_q <= byte_cnt_q + 1'b1;
            if (imem_we_o) begin
                imem_addr_o <= imem_addr_o + 1'b1;
                if (imem_wdata_o == `MIPS_HALT_WORD) begin
                    run_en_o <= 1'b1; // sticky until reset
                end
            end
        end
    end

endmodule

// File: design/fetch_stage.sv
`include "mips_cfg.svh"

module fetch_stage (
    input  logic                     clock_i,
    input  logic                     rst_n_i,
    input  logic                     run_en_i,
    input  logic                     imem_we_i,
    input  logic [`MIPS_IMEM_AW-1:0] imem_addr_i,
    input  logic [`MIPS_DATA_W-1:0]  imem_wdata_i,
    output mips_pkg::if_id_t         if_id_o
);

    logic [`MIPS_DATA_W-1:0]  imem [`MIPS_IMEM_DEPTH];
    logic [`MIPS_IMEM_AW-1:0] pc_q;
    logic [`MIPS_IMEM_AW-1:0] pc_d;
    logic [`MIPS_DATA_W-1:0]  instr_q;

    // hold on halt so it keeps being fetched
    assign pc_d = (run_en_i && instr_q != `MIPS_HALT_WORD) ? pc_q + 1'b1 : pc_q;

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_d;
        end
    end

    // read at the next pc so instr_q lines up with pc_q
    always_ff @(posedge clock_i) begin
        if (imem_we_i) imem[imem_addr_i] <= imem_wdata_i;
        instr_q <= imem[pc_d];
    end

    assign if_id_o.pc    = pc_q;
    assign if_id_o.instr = instr_q;

endmodule

// File: design/decode_stage.sv
`include "mips_cfg.svh"

module decode_stage (
    input  logic                    clock_i,
    input  logic                    rst_n_i,
    input  mips_pkg::if_id_t        if_id_i,
    input  mips_pkg::mem_wb_t       mem_wb_i,
    output mips_pkg::id_ex_t        id_ex_o,
    output logic                    wb_valid_o,
    output logic [`MIPS_REG_AW-1:0] wb_reg_o,
    output logic [`MIPS_DATA_W-1:0] wb_data_o
);

    logic [`MIPS_DATA_W-1:0] regs [`MIPS_NUM_REGS];
    logic [5:0]              opcode;
    logic [5:0]              funct;
    logic [`MIPS_REG_AW-1:0] rs;
    logic [`MIPS_REG_AW-1:0] rt;
    logic [`MIPS_REG_AW-1:0] rd;
    logic [15:0]             imm16;
    logic [`MIPS_DATA_W-1:0] rdata_a;
    logic [`MIPS_DATA_W-1:0] rdata_b;

    assign opcode = if_id_i.instr[31:26];
    assign rs     = if_id_i.instr[25:21];
    assign rt     = if_id_i.instr[20:16];
    assign rd     = if_id_i.instr[15:11];
    assign funct  = if_id_i.instr[5:0];
    assign imm16  = if_id_i.instr[15:0];

    // write-back select, r0 writes never reported
    assign wb_data_o  = mem_wb_i.mem_to_reg ? mem_wb_i.mem_data : mem_wb_i.alu_result;
    assign wb_reg_o   = mem_wb_i.dest;
    assign wb_valid_o = mem_wb_i.reg_write && (mem_wb_i.dest != '0);

    always_ff @(posedge clock_i) begin
        if (rst_n_i && wb_valid_o) regs[wb_reg_o] <= wb_data_o;
    end

    // same-cycle write is bypassed to the read ports
    always_comb begin
        if (rs == '0)                         rdata_a = '0;
        else if (wb_valid_o && wb_reg_o == rs) rdata_a = wb_data_o;
        else                                  rdata_a = regs[rs];
    end

    always_comb begin
        if (rt == '0)                         rdata_b = '0;
        else if (wb_valid_o && wb_reg_o == rt) rdata_b = wb_data_o;
        else                                  rdata_b = regs[rt];
    end

    always_comb begin
        id_ex_o        = '0;
        id_ex_o.op_a   = rdata_a;
        id_ex_o.op_b   = rdata_b;
        id_ex_o.rt     = rt;
        id_ex_o.rd     = rd;
        id_ex_o.alu_op = mips_pkg::alu_pass_b;
        id_ex_o.imm    = {{(`MIPS_DATA_W-16){imm16[15]}}, imm16};
        case (opcode)
            mips_pkg::op_rtype: begin
                id_ex_o.reg_write = 1'b1;
                case (funct)
                    mips_pkg::fn_add: id_ex_o.alu_op = mips_pkg::alu_add;
                    mips_pkg::fn_sub: id_ex_o.alu_op = mips_pkg::alu_sub;
                    mips_pkg::fn_and: id_ex_o.alu_op = mips_pkg::alu_and;
                    mips_pkg::fn_or:  id_ex_o.alu_op = mips_pkg::alu_or;
                    mips_pkg::fn_slt: id_ex_o.alu_op = mips_pkg::alu_slt;
                    default:          id_ex_o.reg_write = 1'b0; // unknown funct is a nop
                endcase
            end
            mips_pkg::op_addi, mips_pkg::op_ori, mips_pkg::op_lw: begin
                id_ex_o.alu_op     = mips_pkg::alu_add;
                id_ex_o.use_imm    = 1'b1;
                id_ex_o.dest_is_rt = 1'b1;
                id_ex_o.reg_write  = 1'b1;
                id_ex_o.mem_read   = (opcode == mips_pkg::op_lw);
                if (opcode == mips_pkg::op_ori) begin
                    id_ex_o.alu_op = mips_pkg::alu_or;
                    id_ex_o.imm    = {{(`MIPS_DATA_W-16){1'b0}}, imm16}; // zero-extended
                end
            end
            mips_pkg::op_sw: begin
                id_ex_o.alu_op    = mips_pkg::alu_add;
                id_ex_o.use_imm   = 1'b1;
                id_ex_o.mem_write = 1'b1;
            end
            mips_pkg::op_halt: id_ex_o.halt = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: design/execute_stage.sv
`include "mips_cfg.svh"

module execute_stage (
    input  mips_pkg::id_ex_t  id_ex_i,
    output mips_pkg::ex_mem_t ex_mem_o
);

    logic [`MIPS_DATA_W-1:0] op_a;
    logic [`MIPS_DATA_W-1:0] op_b;
    logic [`MIPS_DATA_W-1:0] result;

    assign op_a = id_ex_i.op_a;
    assign op_b = id_ex_i.use_imm ? id_ex_i.imm : id_ex_i.op_b;

    always_comb begin
        case (id_ex_i.alu_op)
            mips_pkg::alu_add:    result = op_a + op_b;
            mips_pkg::alu_sub:    result = op_a - op_b;
            mips_pkg::alu_and:    result = op_a & op_b;
            mips_pkg::alu_or:     result = op_a | op_b;
            mips_pkg::alu_slt: begin
                result = {{(`MIPS_DATA_W-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            mips_pkg::alu_pass_b: result = op_b;
            default:              result = op_b;
        endcase
    end

    always_comb begin
        ex_mem_o.alu_result = result;
        ex_mem_o.store_data = id_ex_i.op_b; // rt value for sw
        ex_mem_o.dest       = id_ex_i.dest_is_rt ? id_ex_i.rt : id_ex_i.rd;
        ex_mem_o.mem_read   = id_ex_i.mem_read;
        ex_mem_o.mem_write  = id_ex_i.mem_write;
        ex_mem_o.reg_write  = id_ex_i.reg_write;
        ex_mem_o.halt       = id_ex_i.halt;
    end

endmodule

// File: design/mem_stage.sv
`include "mips_cfg.svh"

module mem_stage (
    input  logic              clock_i,
    input  mips_pkg::ex_mem_t ex_mem_i,
    output mips_pkg::mem_wb_t mem_wb_o
);

    logic [`MIPS_DATA_W-1:0]  dmem [`MIPS_DMEM_DEPTH];
    logic [`MIPS_DMEM_AW-1:0] addr;

    assign addr = ex_mem_i.alu_result[`MIPS_DMEM_AW-1:0]; // word address

    always_ff @(posedge clock_i) begin
        if (ex_mem_i.mem_write) dmem[addr] <= ex_mem_i.store_data;
    end

    always_comb begin
        mem_wb_o.alu_result = ex_mem_i.alu_result;
        mem_wb_o.mem_data   = ex_mem_i.mem_read ? dmem[addr] : '0;
        mem_wb_o.dest       = ex_mem_i.dest;
        mem_wb_o.mem_to_reg = ex_mem_i.mem_read;
        mem_wb_o.reg_write  = ex_mem_i.reg_write;
        mem_wb_o.halt       = ex_mem_i.halt;
    end

endmodule

// File: design/mips_top.sv
`include "mips_cfg.svh"

module mips_top (
    input  logic                    clock_i,
    input  logic                    rst_n_i,
    input  logic                    rx_i,
    output logic                    loaded_o,
    output logic                    halted_o,
    output logic                    wb_valid_o,
    output logic [`MIPS_REG_AW-1:0] wb_reg_o,
    output logic [`MIPS_DATA_W-1:0] wb_data_o
);

    logic [7:0]               rx_byte;
    logic                     rx_byte_valid;
    logic                     imem_we;
    logic [`MIPS_IMEM_AW-1:0] imem_addr;
    logic [`MIPS_DATA_W-1:0]  imem_wdata;
    logic                     run_en;

    mips_pkg::if_id_t  if_id_d;
    mips_pkg::if_id_t  if_id_q;
    mips_pkg::id_ex_t  id_ex_d;
    mips_pkg::id_ex_t  id_ex_q;
    mips_pkg::ex_mem_t ex_mem_d;
    mips_pkg::ex_mem_t ex_mem_q;
    mips_pkg::mem_wb_t mem_wb_d;
    mips_pkg::mem_wb_t mem_wb_q;

    assign loaded_o = run_en;
    assign halted_o = mem_wb_q.halt; // halt has drained to write-back

    uart_rx uart_rx_inst (
        .clock_i      (clock_i),
        .rst_n_i      (rst_n_i),
        .rx_i         (rx_i),
        .byte_o       (rx_byte),
        .byte_valid_o (rx_byte_valid)
    );

    program_loader program_loader_inst (
        .clock_i      (clock_i),
        .rst_n_i      (rst_n_i),
        .byte_i       (rx_byte),
        .byte_valid_i (rx_byte_valid),
        .imem_we_o    (imem_we),
        .imem_addr_o  (imem_addr),
        .imem_wdata_o (imem_wdata),
        .run_en_o     (run_en)
    );

    fetch_stage fetch_stage_inst (
        .clock_i      (clock_i),
        .rst_n_i      (rst_n_i),
        .run_en_i     (run_en),
        .imem_we_i    (imem_we),
        .imem_addr_i  (imem_addr),
        .imem_wdata_i (imem_wdata),
        .if_id_o      (if_id_d)
    );

    pipe_reg #(.payload_t(mips_pkg::if_id_t)) if_id_reg_inst (
        .clock_i (clock_i),
        .rst_n_i (rst_n_i),
        .en_i    (run_en),
        .d_i     (if_id_d),
        .q_o     (if_id_q)
    );

    decode_stage decode_stage_inst (
        .clock_i    (clock_i),
        .rst_n_i    (rst_n_i),
        .if_id_i    (if_id_q),
        .mem_wb_i   (mem_wb_q),
        .id_ex_o    (id_ex_d),
        .wb_valid_o (wb_valid_o),
        .wb_reg_o   (wb_reg_o),
        .wb_data_o  (wb_data_o)
    );

    pipe_reg #(.payload_t(mips_pkg::id_ex_t)) id_ex_reg_inst (
        .clock_i (clock_i),
        .rst_n_i (rst_n_i),
        .en_i    (run_en),
        .d_i     (id_ex_d),
        .q_o     (id_ex_q)
    );

    execute_stage execute_stage_inst (
        .id_ex_i  (id_ex_q),
        .ex_mem_o (ex_mem_d)
    );

    pipe_reg #(.payload_t(mips_pkg::ex_mem_t)) ex_mem_reg_inst (
        .clock_i (clock_i),
        .rst_n_i (rst_n_i),
        .en_i    (run_en),
        .d_i     (ex_mem_d),
        .q_o     (ex_mem_q)
    );

    mem_stage mem_stage_inst (
        .clock_i  (clock_i),
        .ex_mem_i (ex_mem_q),
        .mem_wb_o (mem_wb_d)
    );

    pipe_reg #(.payload_t(mips_pkg::mem_wb_t)) mem_wb_reg_inst (
        .clock_i (clock_i),
        .rst_n_i (rst_n_i),
        .en_i    (run_en),
        .d_i     (mem_wb_d),
        .q_o     (mem_wb_q)
    );

endmodule

// File: testbench/tb_mips_top.sv
`include "mips_cfg.svh"

module tb_mips_top;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int          CLK_PERIOD   = 100;
    localparam int          LOAD_TIMEOUT = 40 * `MIPS_CLKS_PER_BIT;
    localparam int          HALT_TIMEOUT = 2 * `MIPS_IMEM_DEPTH;
    localparam int          QUIET_CYCLES = 20;
    localparam int          NUM_TESTS    = 6;
    localparam int          DMEM_AW      = `MIPS_DMEM_AW;
    localparam logic [31:0] SEED         = 32'hfb733a95;

    logic                    clock;
    logic                    rst_n;
    logic                    rx;
    logic                    loaded;
    logic                    halted;
    logic                    wb_valid;
    logic [`MIPS_REG_AW-1:0] wb_reg;
    logic [`MIPS_DATA_W-1:0] wb_data;

    logic [31:0]        program_words [$];
    logic [39:0]        expected_q [$]; // test id, register, data
    logic [31:0]        model_regs [32];
    logic [31:0]        model_mem [`MIPS_DMEM_DEPTH];
    logic [31:0]        rng_state;
    logic               halt_sending;
    int                 errors [NUM_TESTS+1];
    int                 pending [NUM_TESTS+1];
    int                 cur_test;
    int                 passed;
    int                 failed;

    mips_top mips_top_inst (
        .clock_i    (clock),
        .rst_n_i    (rst_n),
        .rx_i       (rx),
        .loaded_o   (loaded),
        .halted_o   (halted),
        .wb_valid_o (wb_valid),
        .wb_reg_o   (wb_reg),
        .wb_data_o  (wb_data)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [4:0] pick_reg(input int lo, input int span);
        return 5'(32'(lo) + next_rand() % 32'(span));
    endfunction

    function automatic logic [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    task automatic emit(input logic [31:0] word);
        program_words.push_back(word);
        repeat (3) program_words.push_back(32'h0); // no forwarding in the pipeline
    endtask

    // r0 never reports a write-back
    task automatic expect_wb(input int tid, input logic [4:0] rd, input logic [31:0] value);
        if (rd != 5'd0) begin
            model_regs[rd] = value;
            expected_q.push_back({3'(tid), rd, value});
            pending[tid]++;
        end
    endtask

    task automatic r_type(input int tid, input logic [5:0] funct, input logic [4:0] rd,
                          input logic [4:0] rs, input logic [4:0] rt);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        a = model_regs[rs];
        b = model_regs[rt];
        case (funct)
            mips_pkg::fn_add: r = a + b;
            mips_pkg::fn_sub: r = a - b;
            mips_pkg::fn_and: r = a & b;
            mips_pkg::fn_or:  r = a | b;
            default:          r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0; // slt
        endcase
        emit({6'h00, rs, rt, rd, 5'h00, funct});
        expect_wb(tid, rd, r);
    endtask

    task automatic i_type(input int tid, input logic [5:0] op, input logic [4:0] rt,
                          input logic [4:0] rs, input logic [15:0] imm);
        logic [31:0]        base;
        logic [DMEM_AW-1:0] addr;
        base = model_regs[rs];
        addr = DMEM_AW'(base + sext16(imm)); // word address
        emit({op, rs, rt, imm});
        case (op)
            mips_pkg::op_addi: expect_wb(tid, rt, base + sext16(imm));
            mips_pkg::op_ori:  expect_wb(tid, rt, base | {16'h0, imm});
            mips_pkg::op_lw:   expect_wb(tid, rt, model_mem[addr]);
            default:           model_mem[addr] = model_regs[rt];
        endcase
    endtask

    task automatic build_program();
        int                 i;
        logic [DMEM_AW-1:0] a1;
        logic [DMEM_AW-1:0] a2;
        // random start values in r1..r6
        for (i = 1; i <= 6; i++) begin
            i_type(3, mips_pkg::op_addi, 5'(i), 5'd0, 16'(next_rand()));
        end
        for (i = 0; i < 2; i++) begin
            r_type(3, mips_pkg::fn_add, pick_reg(8, 8), pick_reg(1, 6), pick_reg(1, 6));
            r_type(3, mips_pkg::fn_sub, pick_reg(8, 8), pick_reg(1, 6), pick_reg(1, 6));
            r_type(3, mips_pkg::fn_and, pick_reg(8, 8), pick_reg(1, 6), pick_reg(1, 6));
            r_type(3, mips_pkg::fn_or, pick_reg(8, 8), pick_reg(1, 6), pick_reg(1, 6));
            r_type(3, mips_pkg::fn_slt, pick_reg(8, 8), pick_reg(1, 6), pick_reg(1, 6));
            i_type(3, mips_pkg::op_addi, pick_reg(8, 8), pick_reg(1, 6), 16'(next_rand()));
            i_type(3, mips_pkg::op_ori, pick_reg(8, 8), pick_reg(1, 6), 16'(next_rand()));
        end
        // two distinct word addresses
        a1 = DMEM_AW'(next_rand());
        a2 = a1 + DMEM_AW'(32'd1 + next_rand() % 32'd126);
        i_type(4, mips_pkg::op_sw, 5'd1, 5'd0, 16'(a1));
        i_type(4, mips_pkg::op_sw, 5'd2, 5'd0, 16'(a2));
        i_type(4, mips_pkg::op_lw, 5'd20, 5'd0, 16'(a1));
        i_type(4, mips_pkg::op_lw, 5'd21, 5'd0, 16'(a2));
        i_type(5, mips_pkg::op_addi, 5'd0, 5'd0, 16'(next_rand()));
        r_type(5, mips_pkg::fn_add, 5'd0, 5'd1, 5'd2);
        r_type(5, mips_pkg::fn_add, 5'd22, 5'd0, 5'd3); // r22 gets r3 unchanged
        program_words.push_back(`MIPS_HALT_WORD);
    endtask

    task automatic send_bit(input logic b);
        @(posedge clock);
        rx <= b;
        repeat (`MIPS_CLKS_PER_BIT - 1) @(posedge clock);
    endtask

    task automatic send_byte(input logic [7:0] b);
        int i;
        send_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            send_bit(b[i]);
        end
        send_bit(1'b1);
    endtask

    // little-endian, low byte first
    task automatic send_words(input int first, input int last);
        int w;
        int k;
        for (w = first; w < last; w++) begin
            for (k = 0; k < 4; k++) begin
                if (w == program_words.size() - 1 && k == 3) halt_sending = 1'b1;
                send_byte(program_words[w][8*k +: 8]);
            end
        end
    endtask

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("[FAIL] %0t %s: got 0x%h expected 0x%h", $time, name, got, exp);
    endtask

    task automatic report_test(input int tid, input string name);
        if (errors[tid] == 0 && pending[tid] == 0) begin
            passed++;
            $display("test %0d %s: pass", tid, name);
        end else begin
            failed++;
            $display("test %0d %s: fail, %0d errors, %0d write-backs missing",
                     tid, name, errors[tid], pending[tid]);
        end
    endtask

    always @(negedge clock) begin : check_outputs
        logic [39:0] head;
        int          tid;
        if (rst_n) begin
            assert (loaded || (!wb_valid && !halted)) else begin
                $display("%0t: write-back or halt seen before the program was loaded", $time);
                errors[cur_test]++;
            end
            assert (!loaded || halt_sending) else begin
                $display("%0t: loaded_o rose before the halt word was sent", $time);
                errors[cur_test]++;
            end
            if (wb_valid) begin
                assert (expected_q.size() > 0) else begin
                    $display("%0t: unexpected write-back to r%0d", $time, wb_reg);
                    errors[cur_test]++;
                end
                if (expected_q.size() > 0) begin
                    head = expected_q.pop_front();
                    tid  = int'(head[39:37]);
                    pending[tid]--;
                    assert (wb_reg == head[36:32]) else begin
                        show_mismatch("wb_reg_o", 32'(wb_reg), 32'(head[36:32]));
                        errors[tid]++;
                    end
                    assert (wb_data == head[31:0]) else begin
                        show_mismatch("wb_data_o", wb_data, head[31:0]);
                        errors[tid]++;
                    end
                end
            end
        end
    end

    initial begin
        int cycles;
        int half;
        int i;
        int total;
        rx           = 1'b1; // idle line
        rst_n        = 1'b0;
        halt_sending = 1'b0;
        cur_test     = 1;
        passed       = 0;
        failed       = 0;
        rng_state    = SEED;
        for (i = 0; i < 32; i++) model_regs[i] = 32'h0;
        for (i = 0; i < `MIPS_DMEM_DEPTH; i++) model_mem[i] = 32'h0;
        build_program();

        repeat (2) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        assert (!loaded && !halted && !wb_valid) else begin
            $display("%0t: outputs not low after reset", $time);
            errors[1]++;
        end
        half = program_words.size() / 2;
        send_words(0, half);
        @(negedge clock);
        assert (!loaded) else begin
            $display("%0t: loaded_o high after a partial program", $time);
            errors[1]++;
        end
        report_test(1, "reset and partial load");

        cur_test = 2;
        send_words(half, program_words.size());
        cycles = 0;
        while (!loaded && cycles < LOAD_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        assert (loaded) else begin
            $display("%0t: timeout, loaded_o never rose after the halt word", $time);
            errors[2]++;
        end
        report_test(2, "program load");

        cur_test = 6;
        cycles   = 0;
        while (!halted && cycles < HALT_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        assert (halted) else begin
            $display("%0t: timeout, halted_o never rose", $time);
            errors[6]++;
        end
        @(posedge clock);
        report_test(3, "alu and immediate ops");
        report_test(4, "store and load");
        report_test(5, "r0 destination");
        assert (expected_q.size() == 0) else begin
            $display("%0t: %0d write-backs still outstanding at halt", $time, expected_q.size());
            errors[6]++;
        end
        for (i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clock);
            assert (halted) else begin
                $display("%0t: halted_o dropped after the halt", $time);
                errors[6]++;
            end
        end
        report_test(6, "halt and drain");

        total = 0;
        for (i = 0; i <= NUM_TESTS; i++) total += errors[i];
        $display("summary: %0d tests passed, %0d failed, %0d errors", passed, failed, total);
        if (failed == 0 && total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+design
design/mips_pkg.sv
design/pipe_reg.sv
design/uart_rx.sv
design/program_loader.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_stage.sv
design/mips_top.sv
testbench/tb_mips_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
PASS_MSG  ?= TEST OK

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
